// ==== verilog/id_pkg.sv ====
package id_pkg;

    parameter int NUM_REGS_DEFAULT = 32;

    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;

    // NOP has to stay at zero so an empty bundle reads as NOP
    typedef enum logic [5:0] {
        ALU_NOP,
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_OR, ALU_AND,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_LB, ALU_LH, ALU_LW, ALU_LBU, ALU_LHU,
        ALU_SB, ALU_SH, ALU_SW,
        ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
        ALU_JAL, ALU_JALR, ALU_AUIPC
    } alu_op_e;

    typedef enum logic [2:0] {
        SEL_NOP,
        SEL_LOGIC,
        SEL_SHIFT,
        SEL_ARITH,
        SEL_LD_ST,
        SEL_JAL
    } alu_sel_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DECODE,
        ST_ACK
    } fsm_state_e;

    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    // arithmetic and logic
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // memory access width
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_SB  = 3'b000;
    localparam logic [2:0] F3_SH  = 3'b001;
    localparam logic [2:0] F3_SW  = 3'b010;

    // branch compare
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef struct packed {
        logic      wreg;
        reg_addr_t wd;
        word_t     wdata;
    } fwd_t;

    typedef struct packed {
        logic ld_flag;
        fwd_t fwd;
    } ex_fwd_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } wb_t;

    typedef struct packed {
        alu_op_e   aluop;
        alu_sel_e  alusel;
        reg_addr_t wd;
        logic      wreg;
        logic      reg1_read;
        logic      reg2_read;
        logic      b_flag;
        word_t     b_target;
    } dec_ctrl_t;

    typedef struct packed {
        word_t     pc;
        alu_op_e   aluop;
        alu_sel_e  alusel;
        reg_addr_t wd;
        logic      wreg;
        word_t     reg1;
        word_t     reg2;
        word_t     offset;
        logic      b_flag;
        word_t     b_target;
    } id_bundle_t;

endpackage

// ==== verilog/id_decoder.sv ====
`timescale 1ns/1ps

module id_decoder (
    input  id_pkg::inst_t     inst_i,
    input  id_pkg::word_t     pc_i,
    output id_pkg::dec_ctrl_t ctrl_o,
    output id_pkg::word_t     imm_o
);

    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    id_pkg::reg_addr_t rd;
    id_pkg::word_t     imm_i_w;
    id_pkg::word_t     imm_s_w;
    id_pkg::word_t     imm_b_w;
    id_pkg::word_t     imm_u_w;
    id_pkg::word_t     imm_j_w;
    id_pkg::word_t     shamt_w;

    id_pkg::alu_op_e   op;
    logic              rd1;
    logic              rd2;
    logic              wr;
    id_pkg::word_t     imm;

    assign opcode = inst_i[6:0];
    assign rd     = inst_i[11:7];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign imm_i_w = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s_w = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b_w = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u_w = {inst_i[31:12], 12'h000};
    assign imm_j_w = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
    // shift immediates carry only the 5-bit amount
    assign shamt_w = {27'd0, inst_i[24:20]};

    // result group follows from the operation alone
    function automatic id_pkg::alu_sel_e sel_of(id_pkg::alu_op_e op_v);
        case (op_v)
            id_pkg::ALU_ADD, id_pkg::ALU_SUB, id_pkg::ALU_SLT, id_pkg::ALU_SLTU,
            id_pkg::ALU_AUIPC:
                return id_pkg::SEL_ARITH;
            id_pkg::ALU_XOR, id_pkg::ALU_OR, id_pkg::ALU_AND:
                return id_pkg::SEL_LOGIC;
            id_pkg::ALU_SLL, id_pkg::ALU_SRL, id_pkg::ALU_SRA:
                return id_pkg::SEL_SHIFT;
            id_pkg::ALU_LB, id_pkg::ALU_LH, id_pkg::ALU_LW, id_pkg::ALU_LBU,
            id_pkg::ALU_LHU, id_pkg::ALU_SB, id_pkg::ALU_SH, id_pkg::ALU_SW:
                return id_pkg::SEL_LD_ST;
            id_pkg::ALU_JAL, id_pkg::ALU_JALR:
                return id_pkg::SEL_JAL;
            default:
                return id_pkg::SEL_NOP;
        endcase
    endfunction

    always_comb begin
        op  = id_pkg::ALU_NOP;
        rd1 = 1'b0;
        rd2 = 1'b0;
        wr  = 1'b0;
        imm = '0;
        case (opcode)
            id_pkg::OPC_OP_IMM: begin
                rd1 = 1'b1;
                wr  = 1'b1;
                imm = imm_i_w;
                case (funct3)
                    id_pkg::F3_ADD:  op = id_pkg::ALU_ADD;
                    id_pkg::F3_SLT:  op = id_pkg::ALU_SLT;
                    id_pkg::F3_SLTU: op = id_pkg::ALU_SLTU;
                    id_pkg::F3_XOR:  op = id_pkg::ALU_XOR;
                    id_pkg::F3_OR:   op = id_pkg::ALU_OR;
                    id_pkg::F3_AND:  op = id_pkg::ALU_AND;
                    id_pkg::F3_SLL: begin
                        imm = shamt_w;
                        if (funct7 == id_pkg::F7_BASE) begin
                            op = id_pkg::ALU_SLL;
                        end
                    end
                    default: begin
                        imm = shamt_w;
                        if (funct7 == id_pkg::F7_BASE) begin
                            op = id_pkg::ALU_SRL;
                        end else if (funct7 == id_pkg::F7_ALT) begin
                            op = id_pkg::ALU_SRA;
                        end
                    end
                endcase
            end
            id_pkg::OPC_OP: begin
                rd1 = 1'b1;
                rd2 = 1'b1;
                wr  = 1'b1;
                case (funct3)
                    id_pkg::F3_ADD: begin
                        if (funct7 == id_pkg::F7_BASE) begin
                            op = id_pkg::ALU_ADD;
                        end else if (funct7 == id_pkg::F7_ALT) begin
                            op = id_pkg::ALU_SUB;
                        end
                    end
                    id_pkg::F3_SLT:  op = id_pkg::ALU_SLT;
                    id_pkg::F3_SLTU: op = id_pkg::ALU_SLTU;
                    id_pkg::F3_XOR:  op = id_pkg::ALU_XOR;
                    id_pkg::F3_OR:   op = id_pkg::ALU_OR;
                    id_pkg::F3_AND:  op = id_pkg::ALU_AND;
                    id_pkg::F3_SLL:  op = id_pkg::ALU_SLL;
                    default: begin
                        if (funct7 == id_pkg::F7_BASE) begin
                            op = id_pkg::ALU_SRL;
                        end else if (funct7 == id_pkg::F7_ALT) begin
                            op = id_pkg::ALU_SRA;
                        end
                    end
                endcase
                // the alternate funct7 exists only for sub and sra
                if (funct7 != id_pkg::F7_BASE && !(funct7 == id_pkg::F7_ALT
                        && (funct3 == id_pkg::F3_ADD || funct3 == id_pkg::F3_SRL))) begin
                    op = id_pkg::ALU_NOP;
                end
            end
            id_pkg::OPC_LOAD: begin
                rd1 = 1'b1;
                wr  = 1'b1;
                imm = imm_i_w;
                case (funct3)
                    id_pkg::F3_LB:  op = id_pkg::ALU_LB;
                    id_pkg::F3_LH:  op = id_pkg::ALU_LH;
                    id_pkg::F3_LW:  op = id_pkg::ALU_LW;
                    id_pkg::F3_LBU: op = id_pkg::ALU_LBU;
                    id_pkg::F3_LHU: op = id_pkg::ALU_LHU;
                    default:        op = id_pkg::ALU_NOP;
                endcase
            end
            id_pkg::OPC_STORE: begin
                rd1 = 1'b1;
                rd2 = 1'b1;
                imm = imm_s_w;
                case (funct3)
                    id_pkg::F3_SB: op = id_pkg::ALU_SB;
                    id_pkg::F3_SH: op = id_pkg::ALU_SH;
                    id_pkg::F3_SW: op = id_pkg::ALU_SW;
                    default:       op = id_pkg::ALU_NOP;
                endcase
            end
            id_pkg::OPC_BRANCH: begin
                rd1 = 1'b1;
                rd2 = 1'b1;
                imm = imm_b_w;
                case (funct3)
                    id_pkg::F3_BEQ:  op = id_pkg::ALU_BEQ;
                    id_pkg::F3_BNE:  op = id_pkg::ALU_BNE;
                    id_pkg::F3_BLT:  op = id_pkg::ALU_BLT;
                    id_pkg::F3_BGE:  op = id_pkg::ALU_BGE;
                    id_pkg::F3_BLTU: op = id_pkg::ALU_BLTU;
                    id_pkg::F3_BGEU: op = id_pkg::ALU_BGEU;
                    default:         op = id_pkg::ALU_NOP;
                endcase
            end
            id_pkg::OPC_JAL: begin
                op  = id_pkg::ALU_JAL;
                wr  = 1'b1;
                imm = imm_j_w;
            end
            id_pkg::OPC_JALR: begin
                op  = id_pkg::ALU_JALR;
                rd1 = 1'b1;
                wr  = 1'b1;
                imm = imm_i_w;
            end
            id_pkg::OPC_LUI: begin
                // executed as an OR with the zero operand
                op  = id_pkg::ALU_OR;
                wr  = 1'b1;
                imm = imm_u_w;
            end
            id_pkg::OPC_AUIPC: begin
                op  = id_pkg::ALU_AUIPC;
                wr  = 1'b1;
                imm = imm_u_w;
            end
            default: begin
                op = id_pkg::ALU_NOP;
            end
        endcase
    end

    // anything left at NOP collapses to an empty bundle
    always_comb begin
        ctrl_o = '0;
        imm_o  = '0;
        if (op != id_pkg::ALU_NOP) begin
            ctrl_o.aluop     = op;
            ctrl_o.alusel    = sel_of(op);
            ctrl_o.wd        = rd;
            ctrl_o.wreg      = wr;
            ctrl_o.reg1_read = rd1;
            ctrl_o.reg2_read = rd2;
            imm_o            = imm;
            if (opcode == id_pkg::OPC_JAL) begin
                ctrl_o.b_flag   = 1'b1;
                ctrl_o.b_target = pc_i + imm;
            end
        end
    end

endmodule

// ==== verilog/id_regfile.sv ====
`timescale 1ns/1ps

module id_regfile #(
    parameter int NUM_REGS = id_pkg::NUM_REGS_DEFAULT
) (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  id_pkg::reg_addr_t rd_addr_a_i,
    input  id_pkg::reg_addr_t rd_addr_b_i,
    output id_pkg::word_t     rd_data_a_o,
    output id_pkg::word_t     rd_data_b_o,
    input  id_pkg::wb_t       wb_i
);

    id_pkg::word_t regs [NUM_REGS];

    // x0 and indices past the file both behave as x0
    function automatic logic is_live(id_pkg::reg_addr_t addr);
        return (addr != '0) && (int'(addr) < NUM_REGS);
    endfunction

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.we && is_live(wb_i.addr)) begin
            regs[wb_i.addr] <= wb_i.data;
        end
    end

    // write-first, a read of the written index sees the new data
    always_comb begin
        rd_data_a_o = '0;
        rd_data_b_o = '0;
        if (is_live(rd_addr_a_i)) begin
            rd_data_a_o = (wb_i.we && wb_i.addr == rd_addr_a_i) ? wb_i.data : regs[rd_addr_a_i];
        end
        if (is_live(rd_addr_b_i)) begin
            rd_data_b_o = (wb_i.we && wb_i.addr == rd_addr_b_i) ? wb_i.data : regs[rd_addr_b_i];
        end
    end

    a_x0_zero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (rd_addr_a_i != '0 || rd_data_a_o == '0) && (rd_addr_b_i != '0 || rd_data_b_o == '0));

endmodule

// ==== verilog/id_operand_mux.sv ====
`timescale 1ns/1ps

module id_operand_mux (
    input  logic              read_i,
    input  id_pkg::reg_addr_t addr_i,
    input  id_pkg::word_t     imm_i,
    input  id_pkg::word_t     rf_data_i,
    input  id_pkg::ex_fwd_t   ex_fwd_i,
    input  id_pkg::fwd_t      mem_fwd_i,
    output id_pkg::reg_addr_t rf_addr_o,
    output id_pkg::word_t     operand_o,
    output logic              stall_o
);

    logic ex_hit;
    logic mem_hit;

    // address 0 is matched like any other index
    assign ex_hit  = (ex_fwd_i.fwd.wd == addr_i);
    assign mem_hit = mem_fwd_i.wreg && (mem_fwd_i.wd == addr_i);

    // park the read port on x0 when the operand is an immediate
    assign rf_addr_o = read_i ? addr_i : '0;

    always_comb begin
        stall_o   = 1'b0;
        operand_o = rf_data_i;
        if (!read_i) begin
            operand_o = imm_i;
        end else if (ex_fwd_i.ld_flag && ex_hit) begin
            // load data not back yet
            stall_o   = 1'b1;
            operand_o = '0;
        end else if (ex_fwd_i.fwd.wreg && ex_hit) begin
            operand_o = ex_fwd_i.fwd.wdata;
        end else if (mem_hit) begin
            operand_o = mem_fwd_i.wdata;
        end
    end

    a_stall_zero: assert #0 (!stall_o || operand_o == '0);

endmodule

// ==== verilog/id_handshake_fsm.sv ====
`timescale 1ns/1ps

module id_handshake_fsm (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               req_i,
    input  id_pkg::word_t      pc_i,
    input  id_pkg::inst_t      inst_i,
    input  id_pkg::dec_ctrl_t  ctrl_i,
    input  id_pkg::word_t      imm_i,
    input  id_pkg::word_t      reg1_i,
    input  id_pkg::word_t      reg2_i,
    input  logic               stall_a_i,
    input  logic               stall_b_i,
    output id_pkg::inst_t      inst_o,
    output id_pkg::word_t      pc_o,
    output logic               ack_o,
    output id_pkg::id_bundle_t bundle_o,
    output logic               stall_o
);

    id_pkg::fsm_state_e state_q;
    id_pkg::fsm_state_e state_d;

    assign stall_o = (state_q == id_pkg::ST_DECODE) && (stall_a_i || stall_b_i);
    assign ack_o   = (state_q == id_pkg::ST_ACK);

    always_comb begin
        state_d = state_q;
        case (state_q)
            id_pkg::ST_IDLE:   if (req_i) state_d = id_pkg::ST_DECODE;
            id_pkg::ST_DECODE: if (!stall_o) state_d = id_pkg::ST_ACK;
            id_pkg::ST_ACK:    if (!req_i) state_d = id_pkg::ST_IDLE;
            default:           state_d = id_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= id_pkg::ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // latched copy drives the decoder, zero decodes as NOP
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            inst_o <= '0;
            pc_o   <= '0;
        end else if (state_q == id_pkg::ST_IDLE && req_i) begin
            inst_o <= inst_i;
            pc_o   <= pc_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bundle_o <= '0;
        end else if (state_q == id_pkg::ST_DECODE && !stall_o) begin
            bundle_o.pc       <= pc_o;
            bundle_o.aluop    <= ctrl_i.aluop;
            bundle_o.alusel   <= ctrl_i.alusel;
            bundle_o.wd       <= ctrl_i.wd;
            bundle_o.wreg     <= ctrl_i.wreg;
            bundle_o.reg1     <= reg1_i;
            bundle_o.reg2     <= reg2_i;
            bundle_o.offset   <= imm_i;
            bundle_o.b_flag   <= ctrl_i.b_flag;
            bundle_o.b_target <= ctrl_i.b_target;
        end
    end

    a_no_ack_on_stall: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        stall_o |=> !ack_o);

endmodule

// ==== verilog/id_stage.sv ====
`timescale 1ns/1ps

module id_stage #(
    parameter int NUM_REGS = id_pkg::NUM_REGS_DEFAULT
) (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               req_i,
    input  id_pkg::word_t      pc_i,
    input  id_pkg::inst_t      inst_i,
    input  id_pkg::ex_fwd_t    ex_fwd_i,
    input  id_pkg::fwd_t       mem_fwd_i,
    input  id_pkg::wb_t        wb_i,
    output logic               ack_o,
    output id_pkg::id_bundle_t bundle_o,
    output logic               id_stall_o
);

    id_pkg::inst_t     inst_q;
    id_pkg::word_t     pc_q;
    id_pkg::dec_ctrl_t ctrl;
    id_pkg::word_t     imm;
    id_pkg::reg_addr_t rf_addr_a;
    id_pkg::reg_addr_t rf_addr_b;
    id_pkg::word_t     rf_data_a;
    id_pkg::word_t     rf_data_b;
    id_pkg::word_t     reg1;
    id_pkg::word_t     reg2;
    logic              stall_a;
    logic              stall_b;

    id_decoder u_decoder (
        .inst_i (inst_q),
        .pc_i   (pc_q),
        .ctrl_o (ctrl),
        .imm_o  (imm)
    );

    id_regfile #(
        .NUM_REGS (NUM_REGS)
    ) u_regfile (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .rd_addr_a_i (rf_addr_a),
        .rd_addr_b_i (rf_addr_b),
        .rd_data_a_o (rf_data_a),
        .rd_data_b_o (rf_data_b),
        .wb_i        (wb_i)
    );

    // rs1 and rs2 fields of the latched instruction
    id_operand_mux u_mux_a (
        .read_i    (ctrl.reg1_read),
        .addr_i    (inst_q[19:15]),
        .imm_i     (imm),
        .rf_data_i (rf_data_a),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .rf_addr_o (rf_addr_a),
        .operand_o (reg1),
        .stall_o   (stall_a)
    );

    id_operand_mux u_mux_b (
        .read_i    (ctrl.reg2_read),
        .addr_i    (inst_q[24:20]),
        .imm_i     (imm),
        .rf_data_i (rf_data_b),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .rf_addr_o (rf_addr_b),
        .operand_o (reg2),
        .stall_o   (stall_b)
    );

    id_handshake_fsm u_fsm (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .req_i     (req_i),
        .pc_i      (pc_i),
        .inst_i    (inst_i),
        .ctrl_i    (ctrl),
        .imm_i     (imm),
        .reg1_i    (reg1),
        .reg2_i    (reg2),
        .stall_a_i (stall_a),
        .stall_b_i (stall_b),
        .inst_o    (inst_q),
        .pc_o      (pc_q),
        .ack_o     (ack_o),
        .bundle_o  (bundle_o),
        .stall_o   (id_stall_o)
    );

endmodule

// ==== tests/id_stage_tb.sv ====
`timescale 1ns/1ps

module id_stage_tb;

    localparam int TIMEOUT_CYCLES = 50;

    logic               clk;
    logic               arst_n;
    logic               req;
    id_pkg::word_t      pc;
    id_pkg::inst_t      inst;
    id_pkg::ex_fwd_t    ex_fwd;
    id_pkg::fwd_t       mem_fwd;
    id_pkg::wb_t        wb;
    logic               ack;
    id_pkg::id_bundle_t bundle;
    logic               id_stall;

    id_pkg::word_t      model [32];
    logic [31:0]        lcg_state;

    integer             fd;
    integer             n;
    integer             n_cases;
    logic [8*200-1:0]   line;
    logic [8*24-1:0]    name;
    id_pkg::word_t      c_pc;
    id_pkg::inst_t      c_inst;
    logic               c_ld;
    logic               c_exw;
    id_pkg::reg_addr_t  c_exwd;
    id_pkg::word_t      c_exdata;
    logic               c_memw;
    id_pkg::reg_addr_t  c_memwd;
    id_pkg::word_t      c_memdata;
    integer             c_stall;
    integer             e_op;
    integer             e_sel;
    id_pkg::reg_addr_t  e_wd;
    logic               e_wreg;
    logic               e_bflag;
    id_pkg::word_t      e_btgt;
    id_pkg::word_t      e_imm;

    id_stage #(
        .NUM_REGS (32)
    ) u_dut (
        .clk_i      (clk),
        .arst_n_i   (arst_n),
        .req_i      (req),
        .pc_i       (pc),
        .inst_i     (inst),
        .ex_fwd_i   (ex_fwd),
        .mem_fwd_i  (mem_fwd),
        .wb_i       (wb),
        .ack_o      (ack),
        .bundle_o   (bundle),
        .id_stall_o (id_stall)
    );

    always #20 clk = ~clk;

    function automatic id_pkg::word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // register operands per base ISA format
    function automatic logic uses_rs1(id_pkg::inst_t i);
        return i[6:0] == id_pkg::OPC_OP_IMM || i[6:0] == id_pkg::OPC_OP
            || i[6:0] == id_pkg::OPC_LOAD || i[6:0] == id_pkg::OPC_STORE
            || i[6:0] == id_pkg::OPC_BRANCH || i[6:0] == id_pkg::OPC_JALR;
    endfunction

    function automatic logic uses_rs2(id_pkg::inst_t i);
        return i[6:0] == id_pkg::OPC_OP || i[6:0] == id_pkg::OPC_STORE
            || i[6:0] == id_pkg::OPC_BRANCH;
    endfunction

    // bypass priority, ex over mem over the register file
    function automatic id_pkg::word_t expect_operand(logic rd, id_pkg::reg_addr_t addr,
            id_pkg::word_t imm, id_pkg::ex_fwd_t ex, id_pkg::fwd_t mem);
        if (!rd) begin
            return imm;
        end else if (ex.ld_flag && ex.fwd.wd == addr) begin
            return '0;
        end else if (ex.fwd.wreg && ex.fwd.wd == addr) begin
            return ex.fwd.wdata;
        end else if (mem.wreg && mem.wd == addr) begin
            return mem.wdata;
        end
        return model[addr];
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_bundle(input logic [8*24-1:0] tag, input id_pkg::id_bundle_t exp,
            input id_pkg::id_bundle_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("ERROR %0s bundle expected %h actual %h", tag, exp, act));
        end
    endtask

    task automatic check_stall(input logic [8*24-1:0] tag, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("ERROR %0s id_stall expected %b actual %b", tag, exp, act));
        end
    endtask

    task automatic check_ack(input logic [8*24-1:0] tag, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("ERROR %0s ack expected %b actual %b", tag, exp, act));
        end
    endtask

    task automatic wait_ack(input logic [8*24-1:0] tag, input logic level,
            input id_pkg::fsm_state_e target);
        int cycles;
        cycles = 0;
        while (ack !== level) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                stop_on_error($sformatf("%0s: no ack after %0d cycles waiting for state %s",
                    tag, TIMEOUT_CYCLES, target.name()));
            end
        end
    endtask

    task automatic preload_regs();
        id_pkg::word_t value;
        // x0 gets a write as well and has to keep reading zero
        for (int i = 0; i < 32; i++) begin
            value = lcg_next();
            @(posedge clk);
            #2;
            wb = {1'b1, i[4:0], value};
            if (i != 0) begin
                model[i] = value;
            end
        end
        @(posedge clk);
        #2;
        wb = '0;
    endtask

    task automatic run_case();
        id_pkg::id_bundle_t exp;
        id_pkg::ex_fwd_t    ex_clr;
        id_pkg::fwd_t       mem_v;
        logic               rd1;
        logic               rd2;
        logic               exp_stall;
        rd1 = (e_op != 0) && uses_rs1(c_inst);
        rd2 = (e_op != 0) && uses_rs2(c_inst);
        exp_stall = c_ld && ((rd1 && c_exwd == c_inst[19:15]) || (rd2 && c_exwd == c_inst[24:20]));
        // operands settle once the load flag has dropped
        ex_clr = {1'b0, c_exw, c_exwd, c_exdata};
        mem_v  = {c_memw, c_memwd, c_memdata};
        exp.pc       = c_pc;
        exp.aluop    = id_pkg::alu_op_e'(e_op[5:0]);
        exp.alusel   = id_pkg::alu_sel_e'(e_sel[2:0]);
        exp.wd       = e_wd;
        exp.wreg     = e_wreg;
        exp.reg1     = expect_operand(rd1, c_inst[19:15], e_imm, ex_clr, mem_v);
        exp.reg2     = expect_operand(rd2, c_inst[24:20], e_imm, ex_clr, mem_v);
        exp.offset   = e_imm;
        exp.b_flag   = e_bflag;
        exp.b_target = e_btgt;
        @(posedge clk);
        #2;
        pc      = c_pc;
        inst    = c_inst;
        ex_fwd  = {c_ld, c_exw, c_exwd, c_exdata};
        mem_fwd = mem_v;
        req     = 1'b1;
        @(posedge clk);
        #1;
        check_stall(name, exp_stall, id_stall);
        check_ack(name, 1'b0, ack);
        if (exp_stall) begin
            for (int i = 0; i < c_stall; i++) begin
                check_ack(name, 1'b0, ack);
                check_stall(name, 1'b1, id_stall);
                @(posedge clk);
                #1;
            end
            #1;
            ex_fwd.ld_flag = 1'b0;
            wait_ack(name, 1'b1, id_pkg::ST_ACK);
        end else begin
            @(posedge clk);
            #1;
            check_ack(name, 1'b1, ack);
        end
        check_bundle(name, exp, bundle);
        // req held high, bundle must stay put
        repeat (2) begin
            @(posedge clk);
            #1;
            check_ack(name, 1'b1, ack);
            check_bundle(name, exp, bundle);
        end
        #1;
        req     = 1'b0;
        ex_fwd  = '0;
        mem_fwd = '0;
        @(posedge clk);
        #1;
        check_ack(name, 1'b0, ack);
    endtask

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        req       = 1'b0;
        pc        = '0;
        inst      = '0;
        ex_fwd    = '0;
        mem_fwd   = '0;
        wb        = '0;
        lcg_state = 32'd86;
        n_cases   = 0;
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
        repeat (16) @(posedge clk);
        #2;
        arst_n = 1'b1;
        @(posedge clk);
        #1;
        check_ack("reset", 1'b0, ack);
        check_stall("reset", 1'b0, id_stall);
        check_bundle("reset", '0, bundle);
        preload_regs();
        fd = $fopen("tests/id_cases.txt", "r");
        if (fd == 0) begin
            stop_on_error("could not open the case file tests/id_cases.txt");
        end
        while (!$feof(fd)) begin
            line = '0;
            name = '0;
            n = $fgets(line, fd);
            n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %d %d %d %h %h %h %h %h",
                name, c_pc, c_inst, c_ld, c_exw, c_exwd, c_exdata, c_memw, c_memwd,
                c_memdata, c_stall, e_op, e_sel, e_wd, e_wreg, e_bflag, e_btgt, e_imm);
            if (n == 18) begin
                run_case();
                n_cases++;
            end else if (n > 0 && name != "#") begin
                stop_on_error($sformatf("case file line starting with %0s is malformed", name));
            end
        end
        $fclose(fd);
        if (n_cases == 0) begin
            stop_on_error("the case file held no cases");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// ==== tests/id_cases.txt ====
# name pc inst ex_ld ex_wreg ex_wd ex_wdata mem_wreg mem_wd mem_wdata stall_cycles
# then expected aluop alusel as decimal, wd wreg b_flag b_target imm as hex
addi_pos        00000100 06408293 0 0 00 00000000 0 00 00000000 0 1  3 05 1 0 00000000 00000064
addi_neg        00000104 FFF10313 0 0 00 00000000 0 00 00000000 0 1  3 06 1 0 00000000 FFFFFFFF
slti            00000108 0051A393 0 0 00 00000000 0 00 00000000 0 3  3 07 1 0 00000000 00000005
xori            0000010C 0FF24413 0 0 00 00000000 0 00 00000000 0 5  1 08 1 0 00000000 000000FF
slli            00000110 00331513 0 0 00 00000000 0 00 00000000 0 8  2 0A 1 0 00000000 00000003
srai            00000114 41F3D593 0 0 00 00000000 0 00 00000000 0 10 2 0B 1 0 00000000 0000001F
add             00000118 002086B3 0 0 00 00000000 0 00 00000000 0 1  3 0D 1 0 00000000 00000000
sub             0000011C 40418733 0 0 00 00000000 0 00 00000000 0 2  3 0E 1 0 00000000 00000000
or              00000120 0083E833 0 0 00 00000000 0 00 00000000 0 6  1 10 1 0 00000000 00000000
sra             00000124 40A4D8B3 0 0 00 00000000 0 00 00000000 0 10 2 11 1 0 00000000 00000000
lw              00000128 00812903 0 0 00 00000000 0 00 00000000 0 13 4 12 1 0 00000000 00000008
lbu             0000012C FFC1C983 0 0 00 00000000 0 00 00000000 0 14 4 13 1 0 00000000 FFFFFFFC
sw              00000130 00512623 0 0 00 00000000 0 00 00000000 0 18 4 0C 0 0 00000000 0000000C
sh              00000134 FE639F23 0 0 00 00000000 0 00 00000000 0 17 4 1E 0 0 00000000 FFFFFFFE
beq             00000138 00208863 0 0 00 00000000 0 00 00000000 0 19 0 10 0 0 00000000 00000010
bne             0000013C FE419CE3 0 0 00 00000000 0 00 00000000 0 20 0 19 0 0 00000000 FFFFFFF8
bgeu            00000140 0062F263 0 0 00 00000000 0 00 00000000 0 24 0 04 0 0 00000000 00000004
jal_fwd         00001000 001000EF 0 0 00 00000000 0 00 00000000 0 25 5 01 1 1 00001800 00000800
jal_back        00002000 FFDFF06F 0 0 00 00000000 0 00 00000000 0 25 5 00 1 1 00001FFC FFFFFFFC
jalr            00000144 000280E7 0 0 00 00000000 0 00 00000000 0 26 5 01 1 0 00000000 00000000
lui             00000148 12345A37 0 0 00 00000000 0 00 00000000 0 6  1 14 1 0 00000000 12345000
auipc           0000014C FFFFFA97 0 0 00 00000000 0 00 00000000 0 27 3 15 1 0 00000000 FFFFF000
fwd_ex_over_mem 00000150 00208B33 0 1 01 DEADBEEF 1 01 11111111 0 1  3 16 1 0 00000000 00000000
fwd_mem_only    00000154 00418BB3 0 1 09 12345678 1 04 CAFEF00D 0 1  3 17 1 0 00000000 00000000
x0_read         00000158 00500C33 0 0 07 00000000 0 00 00000000 0 1  3 18 1 0 00000000 00000000
load_use        0000015C 00730CB3 1 1 06 0BADF00D 1 06 22222222 3 1  3 19 1 0 00000000 00000000
load_use_store  00000160 0084A023 1 1 08 55AA55AA 0 00 00000000 1 18 4 00 0 0 00000000 00000000
unknown_opcode  00000164 0000007F 0 0 00 00000000 0 00 00000000 0 0  0 00 0 0 00000000 00000000
unknown_funct   00000168 023100B3 0 0 00 00000000 0 00 00000000 0 0  0 00 0 0 00000000 00000000

// ==== build.f ====
verilog/id_pkg.sv
verilog/id_decoder.sv
verilog/id_regfile.sv
verilog/id_operand_mux.sv
verilog/id_handshake_fsm.sv
verilog/id_stage.sv
tests/id_stage_tb.sv
